/* hw/bridge_pkg.sv */
package bridge_pkg;

    // ============================
    // widths
    // ============================
    typedef logic [7:0]         byte_t;
    typedef logic [15:0]        cmd_len_t;
    typedef logic signed [13:0] dac_sample_t;
    typedef logic [7:0]         pin_pattern_t;
    typedef logic [7:0]         src_id_t;
    // 0 to 16 bytes
    typedef logic [4:0]         rec_len_t;
    typedef logic [3:0]         buf_idx_t;

    // ============================
    // frame constants and opcodes
    // ============================
    localparam byte_t   CMD_HDR0    = 8'hAA;
    localparam byte_t   CMD_HDR1    = 8'h55;
    localparam byte_t   UP_HDR0     = 8'hAA;
    localparam byte_t   UP_HDR1     = 8'h44;
    localparam byte_t   OP_PINS     = 8'h10;
    localparam byte_t   OP_DAC      = 8'h20;
    localparam byte_t   OP_ECHO     = 8'h30;
    localparam byte_t   OP_CAPTURE  = 8'h40;
    localparam src_id_t SRC_ECHO    = 8'h30;
    localparam src_id_t SRC_CAPTURE = 8'h40;

    localparam int REC_MAX        = 16;
    localparam int NUM_SOURCES    = 2;
    localparam int SRC_SEL_W      = $clog2(NUM_SOURCES);
    // header, header, source, length and checksum around the data
    localparam int FRAME_OVERHEAD = 5;
    // 6554 / 8192 is about 0.8
    localparam int DAC_GAIN       = 6554;
    localparam int DAC_GAIN_SHIFT = 13;

    typedef enum logic [2:0] {
        DEC_HDR0, DEC_HDR1, DEC_CMD, DEC_LEN_H, DEC_LEN_L, DEC_PAYLOAD, DEC_CSUM
    } decode_state_t;

    typedef enum logic [2:0] {
        FRM_IDLE, FRM_HDR0, FRM_HDR1, FRM_SOURCE, FRM_LENGTH, FRM_DATA, FRM_CSUM
    } framer_state_t;

    // command bus, one producer and many listeners
    typedef struct packed {
        byte_t    cmd_type;
        cmd_len_t cmd_length;
        byte_t    cmd_data;
        cmd_len_t cmd_index;
        logic     cmd_start;
        logic     cmd_data_valid;
        logic     cmd_done;
        logic     cmd_abort;
    } cmd_bus_t;

    // record offered to the framer
    typedef struct packed {
        logic     req;
        src_id_t  source_id;
        rec_len_t length;
        byte_t    data;
    } upload_src_t;

endpackage

/* hw/capture_handler.sv */
`timescale 1ns/100ps

module capture_handler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::cmd_bus_t    cmd_bus,
    input  bridge_pkg::byte_t       dc_in,
    input  logic                    grant,
    input  bridge_pkg::buf_idx_t    rd_idx,
    output bridge_pkg::upload_src_t upload
);
    import bridge_pkg::*;

    byte_t      buffer [REC_MAX];
    rec_len_t   n_q;
    buf_idx_t   wr_idx;
    logic [4:0] hold;
    logic       capturing;
    logic       req_q;
    logic       take;
    logic       busy;
    logic       accept;

    // sample count limited to 1..16
    function automatic rec_len_t clamp_count(input byte_t b);
        if (b == 8'd0) begin
            return 5'd1;
        end
        if (b > REC_MAX) begin
            return 5'(REC_MAX);
        end
        return 5'(b);
    endfunction

    assign busy   = req_q || capturing || (hold != '0);
    assign accept = cmd_bus.cmd_start && (cmd_bus.cmd_type == OP_CAPTURE) && !busy;

    // one dc_in sample per cycle
    always_ff @(posedge clk) begin
        if (capturing) begin
            buffer[wr_idx] <= dc_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            take      <= 1'b0;
            n_q       <= 5'd1;
            wr_idx    <= '0;
            capturing <= 1'b0;
            req_q     <= 1'b0;
            hold      <= '0;
        end else begin
            if (cmd_bus.cmd_start) begin
                take <= accept;
                if (accept) begin
                    n_q <= 5'd1;
                end
            end else if (take && cmd_bus.cmd_data_valid && cmd_bus.cmd_index == 16'd0) begin
                n_q <= clamp_count(cmd_bus.cmd_data);
            end else if (take && (cmd_bus.cmd_done || cmd_bus.cmd_abort)) begin
                take      <= 1'b0;
                capturing <= cmd_bus.cmd_done;
                wr_idx    <= '0;
            end
            // last sample taken, offer the record
            if (capturing) begin
                wr_idx <= wr_idx + 4'd1;
                if (5'(wr_idx) == n_q - 5'd1) begin
                    capturing <= 1'b0;
                    req_q     <= 1'b1;
                end
            end
            if (grant) begin
                req_q <= 1'b0;
                hold  <= n_q + 5'(FRAME_OVERHEAD);
            end else if (hold != '0) begin
                hold <= hold - 5'd1;
            end
        end
    end

    always_comb begin
        upload.req       = req_q;
        upload.source_id = SRC_CAPTURE;
        upload.length    = n_q;
        upload.data      = buffer[rd_idx];
    end

endmodule

/* hw/echo_handler.sv */
`timescale 1ns/100ps

module echo_handler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::cmd_bus_t    cmd_bus,
    input  logic                    grant,
    input  bridge_pkg::buf_idx_t    rd_idx,
    output bridge_pkg::upload_src_t upload
);
    import bridge_pkg::*;

    byte_t      buffer [REC_MAX];
    rec_len_t   count;
    // cycles left in our upload frame
    logic [4:0] hold;
    logic       req_q;
    logic       take;
    logic       busy;
    logic       accept;

    // record pending or still being framed
    assign busy   = req_q || (hold != '0);
    assign accept = cmd_bus.cmd_start && (cmd_bus.cmd_type == OP_ECHO) && !busy;

    // payload past 16 bytes dropped
    always_ff @(posedge clk) begin
        if (take && cmd_bus.cmd_data_valid && count < REC_MAX) begin
            buffer[count[3:0]] <= cmd_bus.cmd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            take  <= 1'b0;
            count <= '0;
            req_q <= 1'b0;
            hold  <= '0;
        end else begin
            if (cmd_bus.cmd_start) begin
                take <= accept;
                if (accept) begin
                    count <= '0;
                end
            end else if (take && cmd_bus.cmd_data_valid && count < REC_MAX) begin
                count <= count + 5'd1;
            end else if (take && (cmd_bus.cmd_done || cmd_bus.cmd_abort)) begin
                take  <= 1'b0;
                req_q <= cmd_bus.cmd_done;
            end
            // grant ends request, buffer held for the frame
            if (grant) begin
                req_q <= 1'b0;
                hold  <= count + 5'(FRAME_OVERHEAD);
            end else if (hold != '0) begin
                hold <= hold - 5'd1;
            end
        end
    end

    always_comb begin
        upload.req       = req_q;
        upload.source_id = SRC_ECHO;
        upload.length    = count;
        upload.data      = buffer[rd_idx];
    end

endmodule

/* hw/frame_decoder.sv */
`timescale 1ns/100ps

module frame_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  bridge_pkg::byte_t   usb_data,
    input  logic                usb_data_valid,
    output bridge_pkg::cmd_bus_t cmd_bus
);
    import bridge_pkg::*;

    logic          valid_d;
    logic          byte_stb;
    decode_state_t state;
    byte_t         len_h;
    byte_t         sum;
    cmd_len_t      idx;

    // ============================
    // usb valid edge detect
    // ============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= usb_data_valid;
        end
    end

    // one pulse per new byte
    assign byte_stb = usb_data_valid & ~valid_d;

    // ============================
    // frame FSM
    // ============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= DEC_HDR0;
            len_h   <= '0;
            sum     <= '0;
            idx     <= '0;
            cmd_bus <= '0;
        end else begin
            // strobes last one cycle
            cmd_bus.cmd_start      <= 1'b0;
            cmd_bus.cmd_data_valid <= 1'b0;
            cmd_bus.cmd_done       <= 1'b0;
            cmd_bus.cmd_abort      <= 1'b0;
            if (byte_stb) begin
                case (state)
                    DEC_HDR0: begin
                        if (usb_data == CMD_HDR0) begin
                            state <= DEC_HDR1;
                        end
                    end
                    DEC_HDR1: begin
                        // bad second header byte, resync
                        state <= (usb_data == CMD_HDR1) ? DEC_CMD : DEC_HDR0;
                    end
                    DEC_CMD: begin
                        cmd_bus.cmd_type <= usb_data;
                        sum              <= usb_data;
                        state            <= DEC_LEN_H;
                    end
                    DEC_LEN_H: begin
                        len_h <= usb_data;
                        sum   <= sum + usb_data;
                        state <= DEC_LEN_L;
                    end
                    DEC_LEN_L: begin
                        cmd_bus.cmd_length <= {len_h, usb_data};
                        cmd_bus.cmd_start  <= 1'b1;
                        sum                <= sum + usb_data;
                        idx                <= '0;
                        // empty payload skips straight to checksum
                        state <= ({len_h, usb_data} == '0) ? DEC_CSUM : DEC_PAYLOAD;
                    end
                    DEC_PAYLOAD: begin
                        cmd_bus.cmd_data       <= usb_data;
                        cmd_bus.cmd_index      <= idx;
                        cmd_bus.cmd_data_valid <= 1'b1;
                        sum                    <= sum + usb_data;
                        idx                    <= idx + 16'd1;
                        if (idx == cmd_bus.cmd_length - 16'd1) begin
                            state <= DEC_CSUM;
                        end
                    end
                    DEC_CSUM: begin
                        // sum of opcode, length and payload
                        cmd_bus.cmd_done  <= (usb_data == sum);
                        cmd_bus.cmd_abort <= (usb_data != sum);
                        state             <= DEC_HDR0;
                    end
                    default: state <= DEC_HDR0;
                endcase
            end
        end
    end

endmodule

/* hw/io_output_handler.sv */
`timescale 1ns/100ps

module io_output_handler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::cmd_bus_t    cmd_bus,
    output bridge_pkg::pin_pattern_t pins,
    output bridge_pkg::dac_sample_t dac_a,
    output bridge_pkg::dac_sample_t dac_b
);
    import bridge_pkg::*;

    pin_pattern_t pins_stg;
    dac_sample_t  a_stg;
    dac_sample_t  b_stg;
    logic         pins_got;
    // one bit per received DAC byte
    logic [3:0]   dac_got;

    // scale to about 0.8 then flip sign bit for offset binary
    function automatic dac_sample_t to_offset(input dac_sample_t s);
        logic signed [27:0] prod;
        logic signed [27:0] scaled;
        prod   = 28'(s) * 28'(DAC_GAIN);
        scaled = prod >>> DAC_GAIN_SHIFT;
        return {~scaled[13], scaled[12:0]};
    endfunction

    // ============================
    // staging
    // ============================
    always_ff @(posedge clk) begin
        if (cmd_bus.cmd_data_valid) begin
            if (cmd_bus.cmd_type == OP_PINS && cmd_bus.cmd_index == 16'd0) begin
                pins_stg <= cmd_bus.cmd_data;
            end
            if (cmd_bus.cmd_type == OP_DAC) begin
                // high byte first, low 14 bits kept
                case (cmd_bus.cmd_index)
                    16'd0:   a_stg[13:8] <= cmd_bus.cmd_data[5:0];
                    16'd1:   a_stg[7:0]  <= cmd_bus.cmd_data;
                    16'd2:   b_stg[13:8] <= cmd_bus.cmd_data[5:0];
                    16'd3:   b_stg[7:0]  <= cmd_bus.cmd_data;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pins_got <= 1'b0;
            dac_got  <= '0;
        end else if (cmd_bus.cmd_start || cmd_bus.cmd_abort) begin
            // new or broken frame drops staged state
            pins_got <= 1'b0;
            dac_got  <= '0;
        end else if (cmd_bus.cmd_data_valid) begin
            if (cmd_bus.cmd_type == OP_PINS && cmd_bus.cmd_index == 16'd0) begin
                pins_got <= 1'b1;
            end
            if (cmd_bus.cmd_type == OP_DAC && cmd_bus.cmd_index < 16'd4) begin
                dac_got[cmd_bus.cmd_index[1:0]] <= 1'b1;
            end
        end
    end

    // ============================
    // commit on good checksum
    // ============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pins  <= '0;
            // offset binary zero
            dac_a <= 14'h2000;
            dac_b <= 14'h2000;
        end else if (cmd_bus.cmd_done) begin
            if (cmd_bus.cmd_type == OP_PINS && pins_got) begin
                pins <= pins_stg;
            end
            if (cmd_bus.cmd_type == OP_DAC && (&dac_got)) begin
                dac_a <= to_offset(a_stg);
                dac_b <= to_offset(b_stg);
            end
        end
    end

endmodule

/* hw/upload_framer.sv */
`timescale 1ns/100ps

module upload_framer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bridge_pkg::upload_src_t echo_src,
    input  bridge_pkg::upload_src_t capture_src,
    output logic                    echo_grant,
    output logic                    capture_grant,
    output bridge_pkg::buf_idx_t    rd_idx,
    output bridge_pkg::byte_t       usb_upload_data,
    output logic                    usb_upload_valid
);
    import bridge_pkg::*;

    upload_src_t            srcs [NUM_SOURCES];
    logic [SRC_SEL_W-1:0]   pick;
    logic [SRC_SEL_W-1:0]   sel_q;
    logic [NUM_SOURCES-1:0] grant_vec;
    logic                   any_req;
    framer_state_t          state;
    src_id_t                src_id_q;
    rec_len_t               len_q;
    byte_t                  sum;

    // index order sets priority
    assign srcs[0] = echo_src;
    assign srcs[1] = capture_src;

    // ============================
    // fixed priority, higher index wins
    // ============================
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            if (srcs[i].req) begin
                pick    = SRC_SEL_W'(i);
                any_req = 1'b1;
            end
        end
    end

    // grant only while idle
    assign grant_vec     = (state == FRM_IDLE && any_req) ? (NUM_SOURCES'(1) << pick) : '0;
    assign echo_grant    = grant_vec[0];
    assign capture_grant = grant_vec[1];

    // winner record latched at grant
    always_ff @(posedge clk) begin
        if (state == FRM_IDLE && any_req) begin
            sel_q    <= pick;
            src_id_q <= srcs[pick].source_id;
            len_q    <= srcs[pick].length;
        end
    end

    // ============================
    // frame FSM, one byte per cycle
    // ============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= FRM_IDLE;
            rd_idx <= '0;
            sum    <= '0;
        end else begin
            case (state)
                FRM_IDLE:   if (any_req) state <= FRM_HDR0;
                FRM_HDR0:   state <= FRM_HDR1;
                FRM_HDR1:   state <= FRM_SOURCE;
                FRM_SOURCE: begin
                    sum   <= src_id_q;
                    state <= FRM_LENGTH;
                end
                FRM_LENGTH: begin
                    sum    <= sum + {3'b000, len_q};
                    rd_idx <= '0;
                    state  <= (len_q == '0) ? FRM_CSUM : FRM_DATA;
                end
                FRM_DATA: begin
                    sum    <= sum + srcs[sel_q].data;
                    rd_idx <= rd_idx + 4'd1;
                    if (5'(rd_idx) == len_q - 5'd1) begin
                        state <= FRM_CSUM;
                    end
                end
                default:    state <= FRM_IDLE;
            endcase
        end
    end

    // byte of the current state
    always_comb begin
        case (state)
            FRM_HDR0:   usb_upload_data = UP_HDR0;
            FRM_HDR1:   usb_upload_data = UP_HDR1;
            FRM_SOURCE: usb_upload_data = src_id_q;
            FRM_LENGTH: usb_upload_data = {3'b000, len_q};
            FRM_DATA:   usb_upload_data = srcs[sel_q].data;
            FRM_CSUM:   usb_upload_data = sum;
            default:    usb_upload_data = '0;
        endcase
    end

    assign usb_upload_valid = (state != FRM_IDLE);

endmodule

/* hw/usb_bridge_top.sv */
`timescale 1ns/100ps

module usb_bridge_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  bridge_pkg::byte_t        usb_data,
    input  logic                     usb_data_valid,
    input  bridge_pkg::byte_t        dc_in,
    output bridge_pkg::pin_pattern_t pins,
    output bridge_pkg::dac_sample_t  dac_a,
    output bridge_pkg::dac_sample_t  dac_b,
    output bridge_pkg::byte_t        usb_upload_data,
    output logic                     usb_upload_valid
);
    import bridge_pkg::*;

    cmd_bus_t    cmd_bus;
    upload_src_t echo_up;
    upload_src_t capture_up;
    logic        echo_grant;
    logic        capture_grant;
    buf_idx_t    rd_idx;

    // ============================
    // decode
    // ============================
    frame_decoder u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .usb_data       (usb_data),
        .usb_data_valid (usb_data_valid),
        .cmd_bus        (cmd_bus)
    );

    // ============================
    // handlers
    // ============================
    io_output_handler u_io (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_bus (cmd_bus),
        .pins    (pins),
        .dac_a   (dac_a),
        .dac_b   (dac_b)
    );

    echo_handler u_echo (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_bus (cmd_bus),
        .grant   (echo_grant),
        .rd_idx  (rd_idx),
        .upload  (echo_up)
    );

    capture_handler u_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd_bus (cmd_bus),
        .dc_in   (dc_in),
        .grant   (capture_grant),
        .rd_idx  (rd_idx),
        .upload  (capture_up)
    );

    // ============================
    // upload
    // ============================
    upload_framer u_framer (
        .clk              (clk),
        .rst_n            (rst_n),
        .echo_src         (echo_up),
        .capture_src      (capture_up),
        .echo_grant       (echo_grant),
        .capture_grant    (capture_grant),
        .rd_idx           (rd_idx),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the usb bridge testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=usb_bridge_tb

if ! verilator --binary --timing --top-module "$TOP" -f usb_bridge.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* testbench/usb_bridge_tests.svh */
`ifndef USB_BRIDGE_TESTS_SVH
`define USB_BRIDGE_TESTS_SVH

// ==============================
// reset and pins
// ==============================
task automatic reset_values();
    check("pins", 32'(pins), 32'h0);
    // offset binary zero on both channels
    check("dac_a", 32'(dac_a), 32'h2000);
    check("dac_b", 32'(dac_b), 32'h2000);
    repeat (20) @(posedge clk);
    check("upload bytes after reset", 32'(up_q.size()), 32'd0);
endtask

task automatic pin_latch();
    byte_t pl[$];
    byte_t b;
    // nonzero so the commit is visible against reset
    b = 8'($urandom_range(255, 1));
    pl.push_back(b);
    send_frame(OP_PINS, pl, 1'b0);
    repeat (2) @(posedge clk);
    check("pins", 32'(pins), 32'(b));
    // inverted pattern with broken checksum must be dropped
    pl[0] = ~b;
    send_frame(OP_PINS, pl, 1'b1);
    repeat (2) @(posedge clk);
    check("pins after bad checksum", 32'(pins), 32'(b));
endtask

// ==============================
// DAC
// ==============================
// gain of about 0.8 then top bit flipped
function automatic logic [13:0] dac_expect(input int s);
    int p;
    p = (s * DAC_GAIN) >>> DAC_GAIN_SHIFT;
    return 14'(p) ^ 14'h2000;
endfunction

task automatic send_dac(input int a, input int b);
    byte_t       pl[$];
    logic [13:0] ua;
    logic [13:0] ub;
    ua = 14'(a);
    ub = 14'(b);
    // high byte first
    pl.push_back({2'b00, ua[13:8]});
    pl.push_back(ua[7:0]);
    pl.push_back({2'b00, ub[13:8]});
    pl.push_back(ub[7:0]);
    send_frame(OP_DAC, pl, 1'b0);
    repeat (2) @(posedge clk);
    check("dac_a", 32'(dac_a), 32'(dac_expect(a)));
    check("dac_b", 32'(dac_b), 32'(dac_expect(b)));
endtask

task automatic dac_scaling();
    int r;
    r = int'($urandom % 16384) - 8192;
    // full scale both ways then zero and a random sample
    send_dac(8191, -8192);
    send_dac(0, r);
endtask

// ==============================
// uploads
// ==============================
task automatic echo_case(input int n);
    byte_t pl[$];
    byte_t exp[$];
    byte_t fr[$];
    bit    ok;
    for (int i = 0; i < n; i++) begin
        pl.push_back(8'($urandom));
        // only the first 16 come back
        if (i < REC_MAX) begin
            exp.push_back(pl[i]);
        end
    end
    check("upload bytes before echo", 32'(up_q.size()), 32'd0);
    send_frame(OP_ECHO, pl, 1'b0);
    collect_upload(fr, ok);
    if (ok) begin
        check_upload($sformatf("echo %0d", n), fr, SRC_ECHO, exp);
    end
endtask

task automatic echo_roundtrip();
    echo_case(5);
    echo_case(20);
endtask

task automatic capture_burst();
    byte_t pl[$];
    byte_t exp[$];
    byte_t fr[$];
    bit    ok;
    // never 00 or FF, so stale buffer words cannot pass
    dc_in <= 8'($urandom_range(254, 1));
    @(posedge clk);
    pl.push_back(8'd4);
    repeat (4) exp.push_back(dc_in);
    send_frame(OP_CAPTURE, pl, 1'b0);
    collect_upload(fr, ok);
    if (ok) begin
        check_upload("capture", fr, SRC_CAPTURE, exp);
    end
endtask

// echo request lands while the capture reply is on the wire
task automatic upload_priority();
    byte_t cap_pl[$];
    byte_t cap_exp[$];
    byte_t echo_pl[$];
    byte_t echo_exp[$];
    byte_t fr[$];
    bit    ok;
    // differs from every word of the last capture
    dc_in <= ~dc_in;
    @(posedge clk);
    cap_pl.push_back(8'd16);
    repeat (16) cap_exp.push_back(dc_in);
    echo_pl.push_back(8'($urandom));
    echo_exp.push_back(echo_pl[0]);
    send_frame(OP_CAPTURE, cap_pl, 1'b0);
    send_frame(OP_ECHO, echo_pl, 1'b0);
    collect_upload(fr, ok);
    if (ok) begin
        check_upload("arbitration first", fr, SRC_CAPTURE, cap_exp);
    end
    collect_upload(fr, ok);
    if (ok) begin
        check_upload("arbitration second", fr, SRC_ECHO, echo_exp);
    end
endtask

`endif

/* testbench/usb_bridge_tb.sv */
`timescale 1ns/100ps

module usb_bridge_tb;
    import bridge_pkg::*;

    logic         clk;
    logic         rst_n;
    byte_t        usb_data;
    logic         usb_data_valid;
    byte_t        dc_in;
    pin_pattern_t pins;
    // raw offset-binary words
    logic [13:0]  dac_a;
    logic [13:0]  dac_b;
    byte_t        usb_upload_data;
    logic         usb_upload_valid;

    int    errors;
    int    checks;
    // upload bytes in arrival order
    byte_t up_q[$];

    // ==============================
    // clock and DUT
    // ==============================
    initial clk = 1'b0;
    always #50 clk = ~clk;

    usb_bridge_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .usb_data         (usb_data),
        .usb_data_valid   (usb_data_valid),
        .dc_in            (dc_in),
        .pins             (pins),
        .dac_a            (dac_a),
        .dac_b            (dac_b),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

    // upload strobes picked up mid-cycle
    always @(negedge clk) begin
        if (usb_upload_valid === 1'b1) begin
            up_q.push_back(usb_upload_data);
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // header, opcode, length, payload, then checksum
    task automatic send_frame(input byte_t op, input byte_t payload[$], input bit bad_csum);
        byte_t    frame[$];
        cmd_len_t len;
        byte_t    sum;
        len = cmd_len_t'(payload.size());
        sum = op + len[15:8] + len[7:0];
        frame.push_back(CMD_HDR0);
        frame.push_back(CMD_HDR1);
        frame.push_back(op);
        frame.push_back(len[15:8]);
        frame.push_back(len[7:0]);
        foreach (payload[i]) begin
            frame.push_back(payload[i]);
            sum = sum + payload[i];
        end
        frame.push_back(bad_csum ? sum + 8'd1 : sum);
        @(posedge clk);
        // valid high two cycles and low two cycles
        foreach (frame[i]) begin
            usb_data       <= frame[i];
            usb_data_valid <= 1'b1;
            repeat (2) @(posedge clk);
            usb_data_valid <= 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    // pops one whole upload frame from header to checksum
    task automatic collect_upload(output byte_t frame[$], output bit got_one);
        int waited;
        int n;
        frame.delete();
        got_one = 1'b0;
        waited  = 0;
        while (!got_one && waited < 2000) begin
            @(posedge clk);
            waited++;
            if (up_q.size() >= 4) begin
                n = 5 + int'(up_q[3]);
                if (up_q.size() >= n) begin
                    repeat (n) frame.push_back(up_q.pop_front());
                    got_one = 1'b1;
                end
            end
        end
        if (!got_one) begin
            errors++;
            $display("collect_upload: no complete upload frame within 2000 cycles");
        end
    endtask

    // expected reply is AA 44, source, length, data and sum
    task automatic check_upload(input string tag, input byte_t frame[$], input src_id_t src,
                                input byte_t data[$]);
        byte_t exp[$];
        byte_t sum;
        sum = src + byte_t'(data.size());
        exp.push_back(UP_HDR0);
        exp.push_back(UP_HDR1);
        exp.push_back(src);
        exp.push_back(byte_t'(data.size()));
        foreach (data[i]) begin
            exp.push_back(data[i]);
            sum = sum + data[i];
        end
        exp.push_back(sum);
        check({tag, " frame size"}, 32'(frame.size()), 32'(exp.size()));
        foreach (exp[i]) begin
            if (i < frame.size()) begin
                check($sformatf("%s byte %0d", tag, i), 32'(frame[i]), 32'(exp[i]));
            end
        end
    endtask

`include "usb_bridge_tests.svh"

    // ==============================
    // main sequence
    // ==============================
    initial begin
        errors         = 0;
        checks         = 0;
        void'($urandom(8));
        rst_n          = 1'b0;
        usb_data       = '0;
        usb_data_valid = 1'b0;
        dc_in          = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        pin_latch();
        dac_scaling();
        echo_roundtrip();
        capture_burst();
        upload_priority();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* usb_bridge.f */
+incdir+testbench
hw/bridge_pkg.sv
hw/frame_decoder.sv
hw/io_output_handler.sv
hw/echo_handler.sv
hw/capture_handler.sv
hw/upload_framer.sv
hw/usb_bridge_top.sv
testbench/usb_bridge_tb.sv
